// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_dac_tpl
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== dac_channel.sv ====
`default_nettype none

module dac_channel
  import dac_sample_pkg::*;
#(
  parameter int DATA_PATH_WIDTH = 2
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                sync_int,
  input  logic [DATA_PATH_WIDTH*SAMPLE_W-1:0] dma_data,
  input  logic [DATA_PATH_WIDTH*SAMPLE_W-1:0] pn7_data,
  input  logic [DATA_PATH_WIDTH*SAMPLE_W-1:0] pn15_data,
  input  src_sel_e                            dac_data_sel,
  input  logic                                dac_mask_enable,
  input  logic [SAMPLE_W-1:0]                 dac_pat_data_0,
  input  logic [SAMPLE_W-1:0]                 dac_pat_data_1,
  output logic [DATA_PATH_WIDTH*SAMPLE_W-1:0] dac_data,
  output logic                                enable
);

  // Phase only moves when a beat holds an odd number of samples
  localparam logic PAT_STEP = 1'(DATA_PATH_WIDTH % 2);

  logic                                pat_phase;
  logic [SAMPLE_W-1:0]                 ramp_q;
  logic [DATA_PATH_WIDTH*SAMPLE_W-1:0] beat;

  // ******************************************************************
  // Test generators, restarted by sync
  // ******************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pat_phase <= 1'b0;
      ramp_q    <= '0;
    end else if (sync_int) begin
      pat_phase <= 1'b0;
      ramp_q    <= '0;
    end else begin
      pat_phase <= pat_phase ^ PAT_STEP;
      ramp_q    <= ramp_q + SAMPLE_W'(DATA_PATH_WIDTH);
    end
  end

  // Source select per sample slot
  always_comb begin
    beat = '0;
    for (int j = 0; j < DATA_PATH_WIDTH; j++) begin
      case (dac_data_sel)
        SRC_DMA:     beat[SAMPLE_W*j +: SAMPLE_W] = dma_data[SAMPLE_W*j +: SAMPLE_W];
        SRC_PATTERN: beat[SAMPLE_W*j +: SAMPLE_W] =
                       (pat_phase ^ j[0]) ? dac_pat_data_1 : dac_pat_data_0;
        SRC_PN7:     beat[SAMPLE_W*j +: SAMPLE_W] = pn7_data[SAMPLE_W*j +: SAMPLE_W];
        SRC_PN15:    beat[SAMPLE_W*j +: SAMPLE_W] = pn15_data[SAMPLE_W*j +: SAMPLE_W];
        SRC_RAMP:    beat[SAMPLE_W*j +: SAMPLE_W] = ramp_q + SAMPLE_W'(j);
        default:     beat[SAMPLE_W*j +: SAMPLE_W] = '0;
      endcase
    end
  end

  // Output register, mask forces zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_data <= '0;
      enable   <= 1'b0;
    end else begin
      dac_data <= dac_mask_enable ? '0 : beat;
      enable   <= (dac_data_sel == SRC_DMA) && !dac_mask_enable;
    end
  end

  a_legal_sel : assert property (
    @(posedge clk) disable iff (!rst_n)
    dac_data_sel inside {SRC_DMA, SRC_PATTERN, SRC_PN7, SRC_PN15, SRC_RAMP}
  ) else $error("illegal source select %0d", dac_data_sel);

endmodule

`default_nettype wire

// ==== dac_ext_sync.sv ====
`default_nettype none

module dac_ext_sync #(
  parameter int EXT_SYNC = 0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic dac_sync,
  input  logic dac_ext_sync_arm,
  input  logic dac_sync_in,
  output logic sync_int,
  output logic dac_sync_in_status
);

  logic arm_d1;
  logic sync_in_d1;
  logic sync_in_d2;
  logic sync_in_d3;
  logic armed;
  logic arm_rise;
  logic sync_in_rise;

  assign arm_rise     = dac_ext_sync_arm & ~arm_d1;
  // Edge detect behind the two-flop synchronizer
  assign sync_in_rise = sync_in_d2 & ~sync_in_d3;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arm_d1     <= 1'b0;
      sync_in_d1 <= 1'b0;
      sync_in_d2 <= 1'b0;
      sync_in_d3 <= 1'b0;
      armed      <= 1'b0;
    end else begin
      arm_d1     <= dac_ext_sync_arm;
      sync_in_d1 <= dac_sync_in;
      sync_in_d2 <= sync_in_d1;
      sync_in_d3 <= sync_in_d2;
      // Arming wins over a simultaneous external pulse
      if (EXT_SYNC == 0) begin
        armed <= 1'b0;
      end else if (arm_rise) begin
        armed <= ~armed;
      end else if (sync_in_rise) begin
        armed <= 1'b0;
      end
    end
  end

  // Armed state holds the generators in sync until the pulse arrives
  assign sync_int           = armed | dac_sync;
  assign dac_sync_in_status = armed;

  a_no_arm_without_ext : assert property (
    @(posedge clk) disable iff (!rst_n) (EXT_SYNC == 0) |-> !armed
  ) else $error("armed flag set with external sync disabled");

endmodule

`default_nettype wire

// ==== dac_framer.sv ====
`default_nettype none

module dac_framer
  import jesd_link_pkg::*;
#(
  parameter int NUM_CHANNELS    = 2,
  parameter int NUM_LANES       = 2,
  parameter int DATA_PATH_WIDTH = 2,
  parameter int OCTETS_PER_BEAT = 4
) (
  input  logic [NUM_CHANNELS*DATA_PATH_WIDTH*OCTETS_PER_SAMPLE*OCTET_W-1:0] dac_data,
  output logic [NUM_LANES*OCTETS_PER_BEAT*OCTET_W-1:0]                      link_data
);

  localparam int SAMPLE_BITS = OCTETS_PER_SAMPLE * OCTET_W;
  localparam int CH_W        = DATA_PATH_WIDTH * SAMPLE_BITS;
  localparam int LANE_W      = OCTETS_PER_BEAT * OCTET_W;
  localparam int LINK_W      = NUM_LANES * LANE_W;

  if (NUM_CHANNELS * DATA_PATH_WIDTH * OCTETS_PER_SAMPLE != NUM_LANES * OCTETS_PER_BEAT)
  begin : g_size_check
    $error("channel octets per beat do not fill the lanes");
  end

  // ******************************************************************
  // Octet stream order: sample time, then channel, then octet MSB first
  // ******************************************************************

  for (genvar t = 0; t < DATA_PATH_WIDTH; t++) begin : g_time
    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
      for (genvar o = 0; o < OCTETS_PER_SAMPLE; o++) begin : g_oct
        localparam int N    = (t * NUM_CHANNELS + c) * OCTETS_PER_SAMPLE + o;
        localparam int LANE = N / OCTETS_PER_BEAT;
        localparam int POS  = N % OCTETS_PER_BEAT;
        localparam int SRC  = CH_W * c + SAMPLE_BITS * t + SAMPLE_BITS - OCTET_W * (o + 1);
        // Lane 0 on top, first octet of a lane in its top byte
        localparam int DST  = LINK_W - LANE_W * (LANE + 1) + LANE_W - OCTET_W * (POS + 1);

        assign link_data[DST +: OCTET_W] = dac_data[SRC +: OCTET_W];
      end
    end
  end

endmodule

`default_nettype wire

// ==== dac_pn_gen.sv ====
`default_nettype none

module dac_pn_gen
  import dac_sample_pkg::*;
#(
  parameter int DATA_PATH_WIDTH = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  sync_int,
  output logic [DATA_PATH_WIDTH*SAMPLE_W-1:0]   pn7_data,
  output logic [DATA_PATH_WIDTH*SAMPLE_W-1:0]   pn15_data
);

  localparam int PN_W = DATA_PATH_WIDTH * SAMPLE_W;

  logic [6:0]       pn7_q;
  logic [14:0]      pn15_q;
  logic [PN_W+14:0] pn7_run;
  logic [PN_W+14:0] pn15_run;

  // Runs a Fibonacci LFSR with taps at len and len-1 for one beat.
  // Returns the beat's bits above the final state.
  function automatic logic [PN_W+14:0] lfsr_run(input logic [14:0] seed, input int len);
    logic [14:0]     s;
    logic [14:0]     mask;
    logic [PN_W-1:0] bits;
    logic            fb;
    s    = seed;
    mask = 15'((1 << len) - 1);
    bits = '0;
    for (int k = 0; k < PN_W; k++) begin
      fb = s[len-1] ^ s[len-2];
      // MSB of sample 0 takes the first bit
      bits[(k / SAMPLE_W) * SAMPLE_W + SAMPLE_W - 1 - (k % SAMPLE_W)] = fb;
      s = {s[13:0], fb} & mask;
    end
    return {bits, s};
  endfunction

  assign pn7_run  = lfsr_run({8'h00, pn7_q}, 7);
  assign pn15_run = lfsr_run(pn15_q, 15);

  assign pn7_data  = pn7_run[PN_W+14:15];
  assign pn15_data = pn15_run[PN_W+14:15];

  // ******************************************************************
  // State registers, all ones while in sync
  // ******************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pn7_q  <= '1;
      pn15_q <= '1;
    end else if (sync_int) begin
      pn7_q  <= '1;
      pn15_q <= '1;
    end else begin
      pn7_q  <= pn7_run[6:0];
      pn15_q <= pn15_run[14:0];
    end
  end

endmodule

`default_nettype wire

// ==== dac_sample_pkg.sv ====
`default_nettype none

// ********************************************************************
// Sample level definitions for the channel datapath
// ********************************************************************

package dac_sample_pkg;

  // Converter sample width
  localparam int SAMPLE_W = 16;

  // Width of the per-channel source select
  localparam int SRC_SEL_W = 4;

  // Width of one crossbar channel select
  localparam int CHAN_SEL_W = 8;

  // Channel sample sources, other codes are illegal
  typedef enum logic [SRC_SEL_W-1:0] {
    SRC_DMA     = 4'd0,
    SRC_PATTERN = 4'd1,
    SRC_PN7     = 4'd2,
    SRC_PN15    = 4'd3,
    SRC_RAMP    = 4'd4
  } src_sel_e;

endpackage

`default_nettype wire

// ==== dac_tpl_core.sv ====
`default_nettype none

module dac_tpl_core
  import dac_sample_pkg::*, jesd_link_pkg::*;
#(
  parameter int NUM_CHANNELS    = 2,
  parameter int NUM_LANES       = 2,
  parameter int DATA_PATH_WIDTH = 2,
  parameter int OCTETS_PER_BEAT = 4,
  parameter int EXT_SYNC        = 0,
  parameter int XBAR_ENABLE     = 1
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [NUM_CHANNELS*DATA_PATH_WIDTH*SAMPLE_W-1:0] dac_ddata,
  input  logic                                             dac_sync,
  input  logic                                             dac_ext_sync_arm,
  input  logic                                             dac_sync_in,
  input  logic [NUM_CHANNELS*SRC_SEL_W-1:0]                dac_data_sel,
  input  logic [NUM_CHANNELS-1:0]                          dac_mask_enable,
  input  logic [NUM_CHANNELS*SAMPLE_W-1:0]                 dac_pat_data_0,
  input  logic [NUM_CHANNELS*SAMPLE_W-1:0]                 dac_pat_data_1,
  input  logic [NUM_CHANNELS*CHAN_SEL_W-1:0]               dac_src_chan_sel,
  output logic [NUM_LANES*OCTETS_PER_BEAT*OCTET_W-1:0]     link_data,
  output logic [NUM_CHANNELS-1:0]                          dac_valid,
  output logic                                             dac_sync_in_status,
  output logic [NUM_CHANNELS-1:0]                          enable
);

  localparam int CH_W   = DATA_PATH_WIDTH * SAMPLE_W;
  localparam int DATA_W = NUM_CHANNELS * CH_W;

  logic              sync_int;
  logic [CH_W-1:0]   pn7_data;
  logic [CH_W-1:0]   pn15_data;
  logic [DATA_W-1:0] xbar_data;
  logic [DATA_W-1:0] chan_data;

  dac_ext_sync #(
    .EXT_SYNC (EXT_SYNC)
  ) i_ext_sync (
    .clk                (clk),
    .rst_n              (rst_n),
    .dac_sync           (dac_sync),
    .dac_ext_sync_arm   (dac_ext_sync_arm),
    .dac_sync_in        (dac_sync_in),
    .sync_int           (sync_int),
    .dac_sync_in_status (dac_sync_in_status)
  );

  // DMA data is withheld while in sync
  assign dac_valid = {NUM_CHANNELS{~sync_int}};

  dac_pn_gen #(
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH)
  ) i_pn_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .sync_int  (sync_int),
    .pn7_data  (pn7_data),
    .pn15_data (pn15_data)
  );

  dac_xbar #(
    .NUM_CHANNELS    (NUM_CHANNELS),
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH),
    .XBAR_ENABLE     (XBAR_ENABLE)
  ) i_xbar (
    .clk              (clk),
    .rst_n            (rst_n),
    .dac_ddata        (dac_ddata),
    .dac_src_chan_sel (dac_src_chan_sel),
    .xbar_data        (xbar_data)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
    dac_channel #(
      .DATA_PATH_WIDTH (DATA_PATH_WIDTH)
    ) i_channel (
      .clk             (clk),
      .rst_n           (rst_n),
      .sync_int        (sync_int),
      .dma_data        (xbar_data[CH_W*i +: CH_W]),
      .pn7_data        (pn7_data),
      .pn15_data       (pn15_data),
      .dac_data_sel    (src_sel_e'(dac_data_sel[SRC_SEL_W*i +: SRC_SEL_W])),
      .dac_mask_enable (dac_mask_enable[i]),
      .dac_pat_data_0  (dac_pat_data_0[SAMPLE_W*i +: SAMPLE_W]),
      .dac_pat_data_1  (dac_pat_data_1[SAMPLE_W*i +: SAMPLE_W]),
      .dac_data        (chan_data[CH_W*i +: CH_W]),
      .enable          (enable[i])
    );
  end

  dac_framer #(
    .NUM_CHANNELS    (NUM_CHANNELS),
    .NUM_LANES       (NUM_LANES),
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH),
    .OCTETS_PER_BEAT (OCTETS_PER_BEAT)
  ) i_framer (
    .dac_data  (chan_data),
    .link_data (link_data)
  );

endmodule

`default_nettype wire

// ==== dac_xbar.sv ====
`default_nettype none

module dac_xbar
  import dac_sample_pkg::*;
#(
  parameter int NUM_CHANNELS    = 2,
  parameter int DATA_PATH_WIDTH = 2,
  parameter int XBAR_ENABLE     = 1
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [NUM_CHANNELS*DATA_PATH_WIDTH*SAMPLE_W-1:0] dac_ddata,
  input  logic [NUM_CHANNELS*CHAN_SEL_W-1:0]               dac_src_chan_sel,
  output logic [NUM_CHANNELS*DATA_PATH_WIDTH*SAMPLE_W-1:0] xbar_data
);

  localparam int CH_W = DATA_PATH_WIDTH * SAMPLE_W;

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_slot
    logic [CH_W-1:0] slot;
    logic [CH_W-1:0] slot_q;

    if (XBAR_ENABLE == 1) begin : g_mux
      logic [CHAN_SEL_W-1:0] sel;

      assign sel  = dac_src_chan_sel[CHAN_SEL_W*i +: CHAN_SEL_W];
      assign slot = dac_ddata[CH_W*sel +: CH_W];

      a_sel_range : assert property (
        @(posedge clk) disable iff (!rst_n) sel < CHAN_SEL_W'(NUM_CHANNELS)
      ) else $error("crossbar select %0d out of range on channel %0d", sel, i);
    end else begin : g_direct
      // Straight mapping, register kept so latency does not change
      assign slot = dac_ddata[CH_W*i +: CH_W];
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        slot_q <= '0;
      end else begin
        slot_q <= slot;
      end
    end

    assign xbar_data[CH_W*i +: CH_W] = slot_q;
  end

endmodule

`default_nettype wire

// ==== jesd_link_pkg.sv ====
`default_nettype none

// ********************************************************************
// Link level definitions for the JESD framer
// ********************************************************************

package jesd_link_pkg;

  // One octet on a lane
  localparam int OCTET_W = 8;

  // A 16 bit sample occupies two octets on the link
  localparam int OCTETS_PER_SAMPLE = 2;

endpackage

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== tb_dac_tpl.sv ====
`default_nettype none

module tb_dac_tpl
  import dac_sample_pkg::*, jesd_link_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NCH         = 2;
  localparam int DPW         = 2;
  localparam int CH_W        = DPW * SAMPLE_W;
  localparam int DATA_W      = NCH * CH_W;
  localparam int LINK_W      = 2 * 4 * OCTET_W;
  localparam int PERIOD_NS   = 20;
  localparam int DMA_BEATS   = 40;
  localparam int PAT_BEATS   = 12;
  localparam int PN_BEATS    = 40;
  localparam int RAMP_BEATS  = 20;
  localparam int EXT_BEATS   = 30;
  localparam int TOTAL_BEATS = DMA_BEATS + PAT_BEATS + PN_BEATS + RAMP_BEATS + EXT_BEATS + 24;
  // Twice the stimulus length leaves room for reset and drain
  localparam int TIMEOUT_NS  = 2 * TOTAL_BEATS * PERIOD_NS;

  logic                   clk;
  logic                   rst_n;
  logic [DATA_W-1:0]      dac_ddata;
  logic                   dac_sync;
  logic                   dac_ext_sync_arm;
  logic                   dac_sync_in;
  logic [NCH*SRC_SEL_W-1:0] dac_data_sel;
  logic [NCH-1:0]         dac_mask_enable;
  logic [NCH*SAMPLE_W-1:0] dac_pat_data_0;
  logic [NCH*SAMPLE_W-1:0] dac_pat_data_1;
  logic [NCH*CHAN_SEL_W-1:0] dac_src_chan_sel;
  logic [LINK_W-1:0]      link_data;
  logic [NCH-1:0]         dac_valid;
  logic                   dac_sync_in_status;
  logic [NCH-1:0]         enable;

  // Reference model state
  logic [15:0]       lfsr_state;
  logic              m_arm_q;
  logic [2:0]        m_in_q;
  logic              m_armed;
  logic              m_sync;
  logic [6:0]        m_pn7;
  logic [14:0]       m_pn15;
  logic [15:0]       m_cnt;
  logic [DATA_W-1:0] m_xbar;
  logic [DATA_W-1:0] m_chan;
  logic [NCH-1:0]    m_en;
  logic [LINK_W-1:0] exp_link;

  tb_clk_gen #(.PERIOD_NS(PERIOD_NS)) i_clk_gen (.clk(clk));

  dac_tpl_core #(
    .NUM_CHANNELS    (NCH),
    .NUM_LANES       (2),
    .DATA_PATH_WIDTH (DPW),
    .OCTETS_PER_BEAT (4),
    .EXT_SYNC        (1),
    .XBAR_ENABLE     (1)
  ) i_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .dac_ddata          (dac_ddata),
    .dac_sync           (dac_sync),
    .dac_ext_sync_arm   (dac_ext_sync_arm),
    .dac_sync_in        (dac_sync_in),
    .dac_data_sel       (dac_data_sel),
    .dac_mask_enable    (dac_mask_enable),
    .dac_pat_data_0     (dac_pat_data_0),
    .dac_pat_data_1     (dac_pat_data_1),
    .dac_src_chan_sel   (dac_src_chan_sel),
    .link_data          (link_data),
    .dac_valid          (dac_valid),
    .dac_sync_in_status (dac_sync_in_status),
    .enable             (enable)
  );

  // ********************************************************************
  // Helpers
  // ********************************************************************

  // x^16+x^14+x^13+x^11+1, new bit enters at the bottom
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One PN step with taps at len and len-1, output bit is the new LSB
  function automatic logic [14:0] pn_shift(input logic [14:0] s, input int len);
    logic fb;
    fb = s[len-1] ^ s[len-2];
    return {s[13:0], fb} & ((15'd1 << len) - 15'd1);
  endfunction

  function automatic logic [CH_W-1:0] pn_bits(input logic [14:0] s, input int len);
    logic [CH_W-1:0] bits;
    bits = '0;
    for (int k = 0; k < CH_W; k++) begin
      s = pn_shift(s, len);
      bits[(k / SAMPLE_W) * SAMPLE_W + SAMPLE_W - 1 - (k % SAMPLE_W)] = s[0];
    end
    return bits;
  endfunction

  function automatic logic [14:0] pn_advance(input logic [14:0] s, input int len);
    for (int k = 0; k < CH_W; k++) begin
      s = pn_shift(s, len);
    end
    return s;
  endfunction

  // Expected beat of one channel before masking
  function automatic logic [CH_W-1:0] chan_beat(
    input src_sel_e sel, input logic [CH_W-1:0] dma, input logic [15:0] p0,
    input logic [15:0] p1, input logic [15:0] cnt, input logic [CH_W-1:0] pn7b,
    input logic [CH_W-1:0] pn15b
  );
    logic [CH_W-1:0] b;
    logic [15:0]     n;
    b = '0;
    for (int j = 0; j < DPW; j++) begin
      n = cnt + 16'(j);
      case (sel)
        SRC_DMA:     b[SAMPLE_W*j +: SAMPLE_W] = dma[SAMPLE_W*j +: SAMPLE_W];
        SRC_PATTERN: b[SAMPLE_W*j +: SAMPLE_W] = n[0] ? p1 : p0;
        SRC_PN7:     b[SAMPLE_W*j +: SAMPLE_W] = pn7b[SAMPLE_W*j +: SAMPLE_W];
        SRC_PN15:    b[SAMPLE_W*j +: SAMPLE_W] = pn15b[SAMPLE_W*j +: SAMPLE_W];
        SRC_RAMP:    b[SAMPLE_W*j +: SAMPLE_W] = n;
        default:     b[SAMPLE_W*j +: SAMPLE_W] = '0;
      endcase
    end
    return b;
  endfunction

  // Samples by time then channel, octets MSB first, streamed from the top of the link word
  function automatic logic [LINK_W-1:0] frame_beat(input logic [DATA_W-1:0] d);
    logic [LINK_W-1:0] w;
    w = '0;
    for (int t = 0; t < DPW; t++) begin
      for (int c = 0; c < NCH; c++) begin
        w = {w[LINK_W-SAMPLE_W-1:0], d[CH_W*c + SAMPLE_W*t +: SAMPLE_W]};
      end
    end
    return w;
  endfunction

  task automatic fill_random(output logic [DATA_W-1:0] w);
    for (int k = 0; k < DATA_W; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w[k] = lfsr_state[0];
    end
  endtask

  task automatic next_beat();
    @(posedge clk);
    #2;
  endtask

  task automatic set_sources(input src_sel_e s0, input src_sel_e s1);
    dac_data_sel = {s1, s0};
  endtask

  task automatic end_in_failure();
    $display("Something failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic fail_value(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    end_in_failure();
  endtask

  // ********************************************************************
  // Reference models, two-cycle delay line of channel beats
  // ********************************************************************

  assign m_sync   = m_armed | dac_sync;
  assign exp_link = frame_beat(m_chan);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_arm_q <= 1'b0;
      m_in_q  <= '0;
      m_armed <= 1'b0;
      m_pn7   <= '1;
      m_pn15  <= '1;
      m_cnt   <= '0;
      m_xbar  <= '0;
      m_chan  <= '0;
      m_en    <= '0;
    end else begin
      m_arm_q <= dac_ext_sync_arm;
      m_in_q  <= {m_in_q[1:0], dac_sync_in};
      if (dac_ext_sync_arm && !m_arm_q) begin
        m_armed <= !m_armed;
      end else if (m_in_q[1] && !m_in_q[2]) begin
        m_armed <= 1'b0;
      end
      for (int c = 0; c < NCH; c++) begin
        m_xbar[CH_W*c +: CH_W] <=
          dac_ddata[CH_W*int'(dac_src_chan_sel[CHAN_SEL_W*c +: CHAN_SEL_W]) +: CH_W];
        m_chan[CH_W*c +: CH_W] <= dac_mask_enable[c] ? '0 : chan_beat(
          src_sel_e'(dac_data_sel[SRC_SEL_W*c +: SRC_SEL_W]), m_xbar[CH_W*c +: CH_W],
          dac_pat_data_0[SAMPLE_W*c +: SAMPLE_W], dac_pat_data_1[SAMPLE_W*c +: SAMPLE_W],
          m_cnt, pn_bits({8'h00, m_pn7}, 7), pn_bits(m_pn15, 15));
        m_en[c] <= (dac_data_sel[SRC_SEL_W*c +: SRC_SEL_W] == SRC_DMA) && !dac_mask_enable[c];
      end
      m_cnt  <= m_sync ? 16'd0 : m_cnt + 16'(DPW);
      m_pn7  <= m_sync ? 7'h7f : 7'(pn_advance({8'h00, m_pn7}, 7));
      m_pn15 <= m_sync ? 15'h7fff : pn_advance(m_pn15, 15);
    end
  end

  a_link : assert property (@(posedge clk) disable iff (!rst_n) link_data == exp_link)
    else fail_value($sformatf("link_data %h, expected %h", $sampled(link_data),
                              $sampled(exp_link)));

  a_enable : assert property (@(posedge clk) disable iff (!rst_n) enable == m_en)
    else fail_value("enable bits differ from the source selection");

  a_valid : assert property (@(posedge clk) disable iff (!rst_n) dac_valid == {NCH{~m_sync}})
    else fail_value("dac_valid does not follow the sync state");

  a_status : assert property (@(posedge clk) disable iff (!rst_n) dac_sync_in_status == m_armed)
    else fail_value("dac_sync_in_status differs from the armed state");

  // ********************************************************************
  // Stimulus
  // ********************************************************************

  initial begin
    rst_n            = 1'b0;
    dac_ddata        = '0;
    dac_sync         = 1'b0;
    dac_ext_sync_arm = 1'b0;
    dac_sync_in      = 1'b0;
    dac_mask_enable  = '0;
    dac_pat_data_0   = {16'hbeef, 16'h1234};
    dac_pat_data_1   = {16'h0f0f, 16'ha5a5};
    // Swapped crossbar, channel 0 takes slot 1
    dac_src_chan_sel = {8'd0, 8'd1};
    lfsr_state       = 16'd76;
    set_sources(SRC_DMA, SRC_DMA);
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    repeat (DMA_BEATS) begin
      fill_random(dac_ddata);
      next_beat();
    end

    set_sources(SRC_PATTERN, SRC_PATTERN);
    dac_sync = 1'b1;
    next_beat();
    dac_sync = 1'b0;
    repeat (PAT_BEATS) next_beat();

    set_sources(SRC_PN7, SRC_PN15);
    dac_sync = 1'b1;
    repeat (2) next_beat();
    dac_sync = 1'b0;
    repeat (PN_BEATS) next_beat();

    // Ramp on channel 0, masked DMA on channel 1
    set_sources(SRC_RAMP, SRC_DMA);
    dac_mask_enable = 2'b10;
    dac_sync = 1'b1;
    next_beat();
    dac_sync = 1'b0;
    repeat (RAMP_BEATS) begin
      fill_random(dac_ddata);
      next_beat();
    end
    dac_mask_enable = '0;

    // Arm, then release with an external pulse so the PN restarts
    set_sources(SRC_PN7, SRC_PN15);
    dac_ext_sync_arm = 1'b1;
    repeat (4) next_beat();
    dac_ext_sync_arm = 1'b0;
    repeat (4) next_beat();
    dac_sync_in = 1'b1;
    next_beat();
    dac_sync_in = 1'b0;
    repeat (EXT_BEATS) next_beat();

    repeat (3) next_beat();
    $display("Everything OK");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the stimulus did not finish", TIMEOUT_NS);
    end_in_failure();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
dac_sample_pkg.sv
jesd_link_pkg.sv
dac_ext_sync.sv
dac_pn_gen.sv
dac_xbar.sv
dac_channel.sv
dac_framer.sv
dac_tpl_core.sv
tb_clk_gen.sv
tb_dac_tpl.sv
